//--- tb.f
+incdir+include
hdl/lsu_pkg.sv
hdl/byte_enable_logic.sv
hdl/data_ram.sv
hdl/lsu_ctrl.sv
hdl/lsu_top.sv
test/lsu_tb.sv

//--- test/lsu_tb.sv
`default_nettype none

module lsu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import lsu_pkg::*;

    localparam int LOAD_WORDS  = 16;   // 13 loads per word
    localparam int STORE_WORDS = 8;    // 12 transactions per word
    localparam int FAULT_TXN   = 30;
    localparam int FLAG_TXN    = 16;
    localparam int HOLD_TXN    = 8;
    localparam int N_TXN       = RAM_WORDS + LOAD_WORDS * 13 + STORE_WORDS * 12
                                 + FAULT_TXN + FLAG_TXN + HOLD_TXN;
    localparam int CYCLE_LIMIT = N_TXN * 10 + 100;

    logic    clk;
    logic    rst;
    logic    req;
    logic    memory_read;
    logic    memory_write;
    funct3_t funct3;
    word_t   address;
    word_t   store_data;
    logic    ack;
    word_t   load_data;
    logic    fault;

    word_t shadow [RAM_WORDS];   // expected RAM contents
    word_t exp_data_q [$];
    logic  exp_fault_q [$];
    word_t got_data_q [$];
    logic  got_fault_q [$];
    event  txn_done;
    int    n_checked = 0;
    int    cycles = 0;

    lsu_top u_lsu_top (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .memory_read  (memory_read),
        .memory_write (memory_write),
        .funct3       (funct3),
        .address      (address),
        .store_data   (store_data),
        .ack          (ack),
        .load_data    (load_data),
        .fault        (fault)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout at %0t ns: the req/ack handshake hung after %0d cycles",
                     $time, cycles);
            $display("FAIL: see errors above");
            $fatal(1, "run timed out");
        end
    end

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "word mismatch on %s", what);
        end
    endtask

    task automatic check_fault(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "bit mismatch on %s", what);
        end
    endtask

    // expected result of one request, updates the shadow memory on a good store
    function automatic void lsu_model(input logic rd, input logic wr, input funct3_t f3,
                                      input word_t addr, input word_t sdata,
                                      output word_t exp_data, output logic exp_fault);
        int    idx;
        int    off;
        int    size;
        logic  sext;
        word_t raw;
        word_t keep;
        idx       = int'(addr[RAM_AW+1:2]);   // high bits wrap
        off       = int'(addr[1:0]);
        exp_data  = '0;
        exp_fault = 1'b0;
        if (rd) begin   // a load wins over a store
            case (f3)
                F3_LB, F3_LBU: size = 1;
                F3_LH, F3_LHU: size = 2;
                F3_LW:         size = 4;
                default:       size = 0;
            endcase
            sext = (f3 == F3_LB) || (f3 == F3_LH);
            if (size == 0 || (off % size) != 0) begin
                exp_fault = 1'b1;   // data stays zero
            end else begin
                raw      = shadow[idx] >> (8 * off);
                keep     = (size == 4) ? '1 : (word_t'(1) << (8 * size)) - 1;
                exp_data = raw & keep;
                if (sext && raw[8 * size - 1]) begin
                    exp_data = exp_data | ~keep;
                end
            end
        end else if (wr) begin
            case (f3)
                F3_SB:   size = 1;
                F3_SH:   size = 2;
                F3_SW:   size = 4;
                default: size = 0;
            endcase
            if (size == 0 || (off % size) != 0) begin
                exp_fault = 1'b1;   // memory untouched
            end else begin
                for (int b = 0; b < size; b++) begin
                    shadow[idx][(off + b) * 8 +: 8] = sdata[b * 8 +: 8];
                end
            end
        end
    endfunction

    function automatic word_t make_addr(input int idx, input int off);
        word_t upper;
        upper = word_t'($urandom) & ~((word_t'(1) << (RAM_AW + 2)) - 1);  // wraps away
        return upper | (word_t'(idx) << 2) | word_t'(off);
    endfunction

    // one full four-phase handshake, req held for extra cycles after ack
    task automatic do_txn(input logic rd, input logic wr, input funct3_t f3,
                          input word_t addr, input word_t sdata, input int hold);
        word_t exp_data;
        logic  exp_fault;
        lsu_model(rd, wr, f3, addr, sdata, exp_data, exp_fault);
        exp_data_q.push_back(exp_data);
        exp_fault_q.push_back(exp_fault);
        @(negedge clk);
        memory_read  = rd;
        memory_write = wr;
        funct3       = f3;
        address      = addr;
        store_data   = sdata;
        req          = 1'b1;
        @(negedge clk);
        while (!ack) begin
            @(negedge clk);
        end
        got_data_q.push_back(load_data);
        got_fault_q.push_back(fault);
        ->txn_done;
        repeat (hold) begin
            @(negedge clk);
            check_fault(ack, 1'b1, "ack while req held");
            check_word(load_data, exp_data, "load_data while req held");
        end
        req          = 1'b0;
        memory_read  = 1'b0;
        memory_write = 1'b0;
        @(negedge clk);
        while (ack) begin
            @(negedge clk);
        end
    endtask

    task automatic issue_load(input funct3_t f3, input int idx, input int off);
        do_txn(1'b1, 1'b0, f3, make_addr(idx, off), $urandom, 0);
    endtask

    task automatic store_and_verify(input funct3_t f3, input int idx, input int off);
        do_txn(1'b0, 1'b1, f3, make_addr(idx, off), $urandom, 0);
        issue_load(F3_LW, idx, 0);   // whole word after the store
    endtask

    initial begin : compare_results
        word_t exp_d;
        word_t got_d;
        logic  exp_f;
        logic  got_f;
        forever begin
            @(txn_done);
            while (got_data_q.size() > 0) begin
                exp_d = exp_data_q.pop_front();
                exp_f = exp_fault_q.pop_front();
                got_d = got_data_q.pop_front();
                got_f = got_fault_q.pop_front();
                check_word(got_d, exp_d, "load_data");
                check_fault(got_f, exp_f, "fault");
                n_checked++;
            end
        end
    end

    initial begin : stimulus
        int    idx;
        word_t data;
        void'($urandom(32'h30e7));
        rst          = 1'b1;
        req          = 1'b0;
        memory_read  = 1'b0;
        memory_write = 1'b0;
        funct3       = '0;
        address      = '0;
        store_data   = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_fault(ack, 1'b0, "ack after reset");
        check_fault(fault, 1'b0, "fault after reset");
        check_word(load_data, '0, "load_data after reset");

        for (int i = 0; i < RAM_WORDS; i++) begin
            data = $urandom;
            data = (i % 2 == 1) ? (data | 32'h8080_8080) : (data & 32'h7f7f_7f7f);
            do_txn(1'b0, 1'b1, F3_SW, make_addr(i, 0), data, 0);
        end

        for (int n = 0; n < LOAD_WORDS; n++) begin
            idx = $urandom_range(RAM_WORDS - 1, 0);
            for (int off = 0; off < 4; off++) begin
                issue_load(F3_LB, idx, off);
                issue_load(F3_LBU, idx, off);
            end
            for (int off = 0; off < 4; off += 2) begin
                issue_load(F3_LH, idx, off);
                issue_load(F3_LHU, idx, off);
            end
            issue_load(F3_LW, idx, 0);
        end

        for (int n = 0; n < STORE_WORDS; n++) begin
            idx = $urandom_range(RAM_WORDS - 1, 0);
            for (int off = 0; off < 4; off++) begin
                store_and_verify(F3_SB, idx, off);
            end
            store_and_verify(F3_SH, idx, 0);
            store_and_verify(F3_SH, idx, 2);
        end

        // misaligned and unknown codes
        idx = $urandom_range(RAM_WORDS - 1, 0);
        for (int off = 1; off < 4; off += 2) begin
            issue_load(F3_LH, idx, off);
            issue_load(F3_LHU, idx, off);
            store_and_verify(F3_SH, idx, off);
        end
        for (int off = 1; off < 4; off++) begin
            issue_load(F3_LW, idx, off);
            store_and_verify(F3_SW, idx, off);
        end
        for (int f = 0; f < 8; f++) begin
            if (!(funct3_t'(f) inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU})) begin
                issue_load(funct3_t'(f), idx, 0);
            end
            if (!(funct3_t'(f) inside {F3_SB, F3_SH, F3_SW})) begin
                store_and_verify(funct3_t'(f), idx, 0);
            end
        end

        for (int n = 0; n < 4; n++) begin
            idx = $urandom_range(RAM_WORDS - 1, 0);
            do_txn(1'b1, 1'b1, funct3_t'($urandom_range(7, 0)),
                   make_addr(idx, $urandom_range(3, 0)), $urandom, 0);   // acts as a load
            issue_load(F3_LW, idx, 0);
            do_txn(1'b0, 1'b0, funct3_t'($urandom_range(7, 0)),
                   make_addr(idx, $urandom_range(3, 0)), $urandom, 0);
            issue_load(F3_LW, idx, 0);
        end

        for (int n = 0; n < HOLD_TXN; n++) begin
            idx = $urandom_range(RAM_WORDS - 1, 0);
            do_txn(1'b1, 1'b0, F3_LW, make_addr(idx, 0), '0,
                   (n == HOLD_TXN - 1) ? 0 : $urandom_range(5, 0));
        end

        @(negedge clk);
        if (n_checked == N_TXN) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("only %0d of %0d transactions were checked", n_checked, N_TXN);
            $display("FAIL: see errors above");
            $fatal(1, "transaction count mismatch");
        end
    end

endmodule

`default_nettype wire

//--- hdl/lsu_top.sv
`default_nettype none

module lsu_top (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             req,
    input  wire logic             memory_read,
    input  wire logic             memory_write,
    input  wire lsu_pkg::funct3_t funct3,
    input  wire lsu_pkg::word_t   address,
    input  wire lsu_pkg::word_t   store_data,
    output logic                  ack,
    output lsu_pkg::word_t        load_data,
    output logic                  fault
);

    import lsu_pkg::*;

    logic              op_read;
    logic              op_write;
    funct3_t           op_funct3;
    logic [1:0]        op_address;     // byte offset in the word
    word_t             op_store_data;
    word_t             op_load_data;
    logic              op_fault;
    word_t             ram_wdata;
    word_t             ram_rdata;
    mask_t             write_mask;
    logic [RAM_AW-1:0] ram_index;

    lsu_ctrl u_lsu_ctrl (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .memory_read   (memory_read),
        .memory_write  (memory_write),
        .funct3        (funct3),
        .address       (address),
        .store_data    (store_data),
        .op_load_data  (op_load_data),
        .op_fault      (op_fault),
        .ack           (ack),
        .load_data     (load_data),
        .fault         (fault),
        .op_read       (op_read),
        .op_write      (op_write),
        .op_funct3     (op_funct3),
        .op_address    (op_address),
        .op_store_data (op_store_data),
        .ram_index     (ram_index)
    );

    byte_enable_logic u_byte_enable_logic (
        .memory_read  (op_read),
        .memory_write (op_write),
        .funct3       (op_funct3),
        .address      (op_address),
        .store_data   (op_store_data),
        .ram_rdata    (ram_rdata),
        .load_data    (op_load_data),
        .ram_wdata    (ram_wdata),
        .write_mask   (write_mask),
        .fault        (op_fault)
    );

    data_ram u_data_ram (
        .clk        (clk),
        .index      (ram_index),
        .wdata      (ram_wdata),
        .write_mask (write_mask),
        .rdata      (ram_rdata)
    );

endmodule

`default_nettype wire

//--- hdl/lsu_ctrl.sv
`default_nettype none

module lsu_ctrl (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       req,
    input  wire logic                       memory_read,
    input  wire logic                       memory_write,
    input  wire lsu_pkg::funct3_t           funct3,
    input  wire lsu_pkg::word_t             address,
    input  wire lsu_pkg::word_t             store_data,
    input  wire lsu_pkg::word_t             op_load_data,
    input  wire logic                       op_fault,
    output logic                            ack,
    output lsu_pkg::word_t                  load_data,
    output logic                            fault,
    output logic                            op_read,
    output logic                            op_write,
    output lsu_pkg::funct3_t                op_funct3,
    output logic [1:0]                      op_address,
    output lsu_pkg::word_t                  op_store_data,
    output logic [lsu_pkg::RAM_AW-1:0]      ram_index
);

    import lsu_pkg::*;

    lsu_state_t        state;
    logic              is_read;         // resolved operation
    logic              is_write;
    funct3_t           req_funct3;
    logic [RAM_AW+1:0] req_address;     // upper address bits wrap
    word_t             req_store_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            is_read   <= 1'b0;
            is_write  <= 1'b0;
            ack       <= 1'b0;
            fault     <= 1'b0;
            load_data <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        is_read  <= memory_read;
                        is_write <= memory_write & ~memory_read;  // read has priority
                        fault    <= 1'b0;
                        state    <= ACCESS;
                    end
                end
                ACCESS: begin
                    if (is_write) begin
                        fault <= op_fault;  // store fault known here
                    end
                    state <= DONE;
                end
                DONE: begin
                    load_data <= op_load_data;  // zero unless a good load
                    if (is_read) begin
                        fault <= op_fault;
                    end
                    ack   <= 1'b1;
                    state <= WAIT_LOW;
                end
                WAIT_LOW: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // request payload, captured with the request
    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            req_funct3     <= funct3;
            req_address    <= address[RAM_AW+1:0];
            req_store_data <= store_data;
        end
    end

    assign op_write      = (state == ACCESS) && is_write;  // one write per request
    assign op_read       = (state == DONE) && is_read;
    assign op_funct3     = req_funct3;
    assign op_address    = req_address[1:0];
    assign op_store_data = req_store_data;
    assign ram_index     = req_address[RAM_AW+1:2];

    // four-phase rule: ack drops only once the core has released req
    a_ack_release: assert property (@(posedge clk) $fell(ack) |-> (!$past(req) || $past(rst)))
        else $error("ack dropped while req still high");

    a_one_op: assert property (@(posedge clk) disable iff (rst) !(op_read && op_write))
        else $error("read and write issued together");

endmodule

`default_nettype wire

//--- hdl/data_ram.sv
`default_nettype none

module data_ram (
    input  wire logic                       clk,
    input  wire logic [lsu_pkg::RAM_AW-1:0] index,
    input  wire lsu_pkg::word_t             wdata,
    input  wire lsu_pkg::mask_t             write_mask,
    output lsu_pkg::word_t                  rdata
);

    import lsu_pkg::*;

    word_t mem [RAM_WORDS];  // word array, one byte per mask bit

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < MASK_W; lane++) begin
            if (write_mask[lane]) begin
                mem[index][lane*8 +: 8] <= wdata[lane*8 +: 8];
            end
        end
        rdata <= mem[index];  // old data on read-during-write
    end

    // a write with an unknown index would corrupt an unknown word
    a_index_known: assert property (@(posedge clk) (write_mask != '0) |-> !$isunknown(index))
        else $error("write with unknown index");

endmodule

`default_nettype wire

//--- hdl/byte_enable_logic.sv
`default_nettype none

module byte_enable_logic (
    input  wire logic             memory_read,
    input  wire logic             memory_write,
    input  wire lsu_pkg::funct3_t funct3,
    input  wire logic [1:0]       address,
    input  wire lsu_pkg::word_t   store_data,
    input  wire lsu_pkg::word_t   ram_rdata,
    output lsu_pkg::word_t        load_data,
    output lsu_pkg::word_t        ram_wdata,
    output lsu_pkg::mask_t        write_mask,
    output logic                  fault
);

    import lsu_pkg::*;

    logic [7:0]  byte_sel;  // lane picked by address
    logic [15:0] half_sel;  // half picked by address[1]

    always_comb begin
        case (address)
            2'b00:   byte_sel = ram_rdata[7:0];
            2'b01:   byte_sel = ram_rdata[15:8];
            2'b10:   byte_sel = ram_rdata[23:16];
            default: byte_sel = ram_rdata[31:24];
        endcase
        half_sel = address[1] ? ram_rdata[31:16] : ram_rdata[15:0];
    end

    always_comb begin
        load_data  = '0;
        ram_wdata  = '0;
        write_mask = '0;
        fault      = 1'b0;

        if (memory_read) begin  // read wins if both flags are set
            case (funct3)
                F3_LB: begin
                    load_data = {{24{byte_sel[7]}}, byte_sel};  // sign-extend
                end
                F3_LBU: begin
                    load_data = {24'b0, byte_sel};              // zero-extend
                end
                F3_LH, F3_LHU: begin
                    if (address[0]) begin
                        fault = 1'b1;  // odd half-word address
                    end else if (funct3 == F3_LHU) begin
                        load_data = {16'b0, half_sel};
                    end else begin
                        load_data = {{16{half_sel[15]}}, half_sel};
                    end
                end
                F3_LW: begin
                    if (address != 2'b00) begin
                        fault = 1'b1;
                    end else begin
                        load_data = ram_rdata;
                    end
                end
                default: begin
                    fault = 1'b1;  // no such load
                end
            endcase
        end else if (memory_write) begin
            case (funct3)
                F3_SB: begin
                    ram_wdata  = {MASK_W{store_data[7:0]}};
                    write_mask = mask_t'(1) << address;  // one lane
                end
                F3_SH: begin
                    if (address[0]) begin
                        fault = 1'b1;
                    end else begin
                        ram_wdata  = {2{store_data[15:0]}};
                        write_mask = address[1] ? 4'b1100 : 4'b0011;
                    end
                end
                F3_SW: begin
                    if (address != 2'b00) begin
                        fault = 1'b1;
                    end else begin
                        ram_wdata  = store_data;
                        write_mask = '1;
                    end
                end
                default: begin
                    fault = 1'b1;  // no such store
                end
            endcase
        end
    end

    // the RAM must only ever see byte, aligned half or full word lanes
    a_mask_legal: assert final (write_mask inside {4'b0000, 4'b0001, 4'b0010, 4'b0100,
                                                   4'b1000, 4'b0011, 4'b1100, 4'b1111})
        else $error("illegal write mask %b", write_mask);

endmodule

`default_nettype wire

//--- hdl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    localparam int XLEN      = 32;
    localparam int MASK_W    = XLEN / 8;            // one bit per byte lane
    localparam int RAM_WORDS = 256;
    localparam int RAM_AW    = $clog2(RAM_WORDS);   // word index width

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [MASK_W-1:0] mask_t;
    typedef logic [2:0]        funct3_t;

    `include "lsu_funct3.svh"

    // handshake controller states
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        ACCESS   = 2'd1,
        DONE     = 2'd2,
        WAIT_LOW = 2'd3
    } lsu_state_t;

endpackage

`default_nettype wire

//--- include/lsu_funct3.svh
`ifndef LSU_FUNCT3_SVH
`define LSU_FUNCT3_SVH

// RV32I load funct3 codes
localparam funct3_t F3_LB  = 3'b000;
localparam funct3_t F3_LH  = 3'b001;
localparam funct3_t F3_LW  = 3'b010;
localparam funct3_t F3_LBU = 3'b100;
localparam funct3_t F3_LHU = 3'b101;

// RV32I store funct3 codes
localparam funct3_t F3_SB  = 3'b000;
localparam funct3_t F3_SH  = 3'b001;
localparam funct3_t F3_SW  = 3'b010;

`endif
